//--- src/frv_pkg.sv
// ----------------------------------------
// Core package for the machine-level system block
// Word types, MMIO window layout and memory bus payloads
// ----------------------------------------
package frv_pkg;

  // ----------------------------------------
  // Base types
  typedef logic [31:0] word_t;   // Data or address word
  typedef logic [ 3:0] strb_t;   // Byte write strobe
  typedef logic [63:0] ctr_t;    // Counter value

  // ----------------------------------------
  // MMIO window holding the timer registers
  localparam word_t MMIO_BASE_ADDR = 32'h0000_1000;  // Window base
  localparam word_t MMIO_BASE_MASK = 32'hFFFF_F000;  // Window select bits

  localparam word_t MMIO_OFS_MTIME_LO    = 32'h0;    // mtime [31:0]
  localparam word_t MMIO_OFS_MTIME_HI    = 32'h4;    // mtime [63:32]
  localparam word_t MMIO_OFS_MTIMECMP_LO = 32'h8;    // mtimecmp [31:0]
  localparam word_t MMIO_OFS_MTIMECMP_HI = 32'hC;    // mtimecmp [63:32]

  // ----------------------------------------
  // Memory bus payloads
  typedef struct packed {
    logic  wen;      // Write enable
    strb_t strb;     // Write strobe
    word_t addr;     // Read/write address
    word_t wdata;    // Write data
  } mem_req_t;

  typedef struct packed {
    logic  error;    // Access fault
    word_t rdata;    // Read data
  } mem_rsp_t;

  // Counter values as seen by the CSR file
  typedef struct packed {
    ctr_t cycle;     // Clock cycles
    ctr_t instret;   // Retired instructions
    ctr_t mtime;     // Real time
  } ctr_bundle_t;

  // mcountinhibit style stop bits
  typedef struct packed {
    logic cy;        // Stop cycle
    logic tm;        // Stop time
    logic ir;        // Stop instret
  } inhibit_t;

endpackage

//--- src/frv_irq_pkg.sv
// ----------------------------------------
// Interrupt package
// Trap cause codes, enable/pending bits, trap FSM states
// ----------------------------------------
package frv_irq_pkg;

  // ----------------------------------------
  // Cause codes
  typedef logic [5:0] cause_t;       // Trap cause as written to mcause
  typedef logic [3:0] ext_cause_t;   // External controller cause code

  localparam cause_t CAUSE_NMI      = 6'd0;   // Non-maskable interrupt
  localparam cause_t CAUSE_MSI      = 6'd3;   // Machine software interrupt
  localparam cause_t CAUSE_MTI      = 6'd7;   // Machine timer interrupt
  localparam cause_t CAUSE_MEI_BASE = 6'd16;  // Plus external cause code

  // ----------------------------------------
  // One bit per maskable source, for mie and mip alike
  typedef struct packed {
    logic meip;    // External
    logic mtip;    // Timer
    logic msip;    // Software
  } irq_bits_t;

  // Trap request FSM
  typedef enum logic {
    TRAP_IDLE,     // Waiting for an enabled source
    TRAP_REQ       // Request held until write-back acks
  } trap_state_e;

endpackage

//--- src/frv_counters.sv
// ----------------------------------------
// Counters and timer
// cycle, instret and mtime counters, mtimecmp register,
// MMIO access to the timer and the timer interrupt
// ----------------------------------------
module frv_counters
  import frv_pkg::*;
(
  input  logic        g_clk,            // Global clock
  input  logic        arst_n,           // Async reset, active low
  input  logic        instr_ret,        // Instruction retired
  input  inhibit_t    inhibit,          // Counter stop bits
  input  logic        mmio_en,          // MMIO access strobe
  input  mem_req_t    mmio_req,         // MMIO access payload
  output mem_rsp_t    mmio_rsp,         // Registered MMIO response
  output ctr_bundle_t ctr,              // Counter values
  output logic        timer_interrupt   // mtime reached mtimecmp
);

  ctr_t  cycle_q;                       // Cycle counter
  ctr_t  instret_q;                     // Retire counter
  ctr_t  mtime_q;                       // Time counter
  ctr_t  mtimecmp_q;                    // Timer compare value
  word_t mmio_ofs;                      // Offset inside the window
  logic  sel_time_lo;                   // Offset decodes
  logic  sel_time_hi;
  logic  sel_cmp_lo;
  logic  sel_cmp_hi;
  logic  wr_en;                         // MMIO write this cycle
  word_t rdata;                         // Read mux output

  // Byte-wise merge of a strobed write into a register word
  function automatic word_t merge_strb(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];  // Take new byte
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // MMIO decode
  assign mmio_ofs    = mmio_req.addr & ~MMIO_BASE_MASK;
  assign sel_time_lo = (mmio_ofs == MMIO_OFS_MTIME_LO);
  assign sel_time_hi = (mmio_ofs == MMIO_OFS_MTIME_HI);
  assign sel_cmp_lo  = (mmio_ofs == MMIO_OFS_MTIMECMP_LO);
  assign sel_cmp_hi  = (mmio_ofs == MMIO_OFS_MTIMECMP_HI);
  assign wr_en       = mmio_en & mmio_req.wen;

  assign rdata = ({32{sel_time_lo}} & mtime_q[31:0])     |
                 ({32{sel_time_hi}} & mtime_q[63:32])    |
                 ({32{sel_cmp_lo}}  & mtimecmp_q[31:0])  |
                 ({32{sel_cmp_hi}}  & mtimecmp_q[63:32]);

  // Response comes back one cycle after the access
  always_ff @(posedge g_clk) begin
    if (mmio_en) begin
      mmio_rsp.rdata <= rdata;
      mmio_rsp.error <= ~(sel_time_lo | sel_time_hi | sel_cmp_lo | sel_cmp_hi);
    end
  end

  // ----------------------------------------
  // Performance counters
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      cycle_q   <= '0;
      instret_q <= '0;
    end else begin
      if (!inhibit.cy) begin
        cycle_q <= cycle_q + 1'b1;                  // Every clock
      end
      if (instr_ret && !inhibit.ir) begin
        instret_q <= instret_q + 1'b1;              // Visible next cycle
      end
    end
  end

  // Real time, MMIO write wins over the increment
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      mtime_q <= '0;
    end else if (wr_en && sel_time_lo) begin
      mtime_q[31:0] <= merge_strb(mtime_q[31:0], mmio_req.wdata, mmio_req.strb);
    end else if (wr_en && sel_time_hi) begin
      mtime_q[63:32] <= merge_strb(mtime_q[63:32], mmio_req.wdata, mmio_req.strb);
    end else if (!inhibit.tm) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Compare register, all ones keeps the timer quiet
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      mtimecmp_q <= '1;
    end else if (wr_en && sel_cmp_lo) begin
      mtimecmp_q[31:0] <= merge_strb(mtimecmp_q[31:0], mmio_req.wdata, mmio_req.strb);
    end else if (wr_en && sel_cmp_hi) begin
      mtimecmp_q[63:32] <= merge_strb(mtimecmp_q[63:32], mmio_req.wdata, mmio_req.strb);
    end
  end

  // ----------------------------------------
  // Timer interrupt, one cycle behind the compare
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      timer_interrupt <= 1'b0;
    end else begin
      timer_interrupt <= (mtime_q >= mtimecmp_q);
    end
  end

  assign ctr.cycle   = cycle_q;
  assign ctr.instret = instret_q;
  assign ctr.mtime   = mtime_q;

endmodule

//--- src/frv_interrupt.sv
// ----------------------------------------
// Interrupt controller
// Registers pending sources, picks the highest priority one
// and holds a trap request until write-back acks it
// ----------------------------------------
module frv_interrupt
  import frv_irq_pkg::*;
(
  input  logic       g_clk,            // Global clock
  input  logic       arst_n,           // Async reset, active low
  input  logic       mstatus_mie,      // Global interrupt enable
  input  irq_bits_t  mie,              // Per-source enables
  input  logic       nmi_pending,      // Non-maskable interrupt line
  input  logic       ex_pending,       // External interrupt line
  input  ext_cause_t ex_cause,         // External cause code
  input  logic       ti_pending,       // Timer interrupt from counters
  input  logic       sw_pending,       // Software interrupt line
  input  logic       int_trap_ack,     // Write-back took the trap
  output irq_bits_t  mip,              // Registered pending bits
  output logic       int_trap_req,     // Trap request to write-back
  output cause_t     int_trap_cause    // Cause of the request
);

  trap_state_e state_q;                // FSM state
  trap_state_e state_d;
  logic        nmi_q;                  // Registered NMI line
  ext_cause_t  ex_cause_q;             // Cause code aligned with meip
  irq_bits_t   en_pend;                // Pending and enabled
  logic        take;                   // Some source wants a trap
  cause_t      sel_cause;              // Winning cause
  cause_t      cause_q;                // Held cause

  // ----------------------------------------
  // Pending bits
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      mip   <= '0;
      nmi_q <= 1'b0;
    end else begin
      mip.meip <= ex_pending;
      mip.mtip <= ti_pending;
      mip.msip <= sw_pending;
      nmi_q    <= nmi_pending;
    end
  end

  always_ff @(posedge g_clk) begin
    ex_cause_q <= ex_cause;            // Travels with meip
  end

  // ----------------------------------------
  // Priority: NMI, external, software, timer
  assign en_pend = mip & mie & {3{mstatus_mie}};
  assign take    = nmi_q | (|en_pend);  // NMI bypasses enables

  always_comb begin
    if (nmi_q) begin
      sel_cause = CAUSE_NMI;
    end else if (en_pend.meip) begin
      sel_cause = CAUSE_MEI_BASE + cause_t'(ex_cause_q);
    end else if (en_pend.msip) begin
      sel_cause = CAUSE_MSI;
    end else begin
      sel_cause = CAUSE_MTI;
    end
  end

  // ----------------------------------------
  // Request FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      TRAP_IDLE: if (take) state_d = TRAP_REQ;          // Latch a request
      TRAP_REQ:  if (int_trap_ack) state_d = TRAP_IDLE; // Back to idle a cycle
      default:   state_d = TRAP_IDLE;
    endcase
  end

  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= TRAP_IDLE;
      cause_q <= CAUSE_NMI;
    end else begin
      state_q <= state_d;
      if (state_q == TRAP_IDLE && take) begin
        cause_q <= sel_cause;          // Frozen while requesting
      end
    end
  end

  assign int_trap_req   = (state_q == TRAP_REQ);
  assign int_trap_cause = cause_q;

endmodule

//--- src/frv_mem_arbiter.sv
// ----------------------------------------
// Memory arbiter
// Shares one memory bus between fetch and data ports,
// diverts data accesses in the MMIO window to the counters
// ----------------------------------------
module frv_mem_arbiter
  import frv_pkg::*;
(
  input  logic     g_clk,       // Global clock
  input  logic     arst_n,      // Async reset, active low
  input  logic     imem_req,    // Fetch request
  input  mem_req_t imem_pkt,    // Fetch payload
  output logic     imem_gnt,    // Fetch granted
  output logic     imem_recv,   // Fetch response pulse
  output mem_rsp_t imem_rsp,    // Fetch response
  input  logic     dmem_req,    // Data request
  input  mem_req_t dmem_pkt,    // Data payload
  output logic     dmem_gnt,    // Data granted
  output logic     dmem_recv,   // Data response pulse
  output mem_rsp_t dmem_rsp,    // Data response
  output logic     mem_req,     // Bus request
  output mem_req_t mem_pkt,     // Bus payload
  input  logic     mem_gnt,     // Bus grant
  input  logic     mem_recv,    // Bus response pulse
  input  mem_rsp_t mem_rsp,     // Bus response
  output logic     mmio_en,     // Counter access strobe
  output mem_req_t mmio_req,    // Counter access payload
  input  mem_rsp_t mmio_rsp     // Counter response, one cycle later
);

  logic     busy_q;             // Transaction outstanding
  logic     owner_q;            // 1 = data port owns it
  logic     mmio_q;             // Outstanding one targets MMIO
  logic     win_req;            // Any port asking
  logic     sel_d;              // Data port wins this cycle
  logic     win_mmio;           // Winner hits the MMIO window
  logic     gnt_any;            // Grant issued this cycle
  logic     recv_any;           // Response returns this cycle
  mem_rsp_t rsp;                // Steered response

  // ----------------------------------------
  // Winner selection, data first
  assign win_req  = imem_req | dmem_req;
  assign sel_d    = dmem_req;
  assign win_mmio = sel_d && ((dmem_pkt.addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR);

  // MMIO side, only data accesses
  assign mmio_en  = ~busy_q & win_mmio;
  assign mmio_req = dmem_pkt;

  // Bus side
  assign mem_req  = ~busy_q & win_req & ~win_mmio;
  assign mem_pkt  = sel_d ? dmem_pkt : imem_pkt;

  // MMIO grants at once, the bus grants through mem_gnt
  assign gnt_any  = mmio_en | (mem_req & mem_gnt);
  assign dmem_gnt = gnt_any & sel_d;
  assign imem_gnt = gnt_any & ~sel_d;

  // ----------------------------------------
  // Response routing
  assign recv_any  = busy_q & (mmio_q | mem_recv);  // MMIO answers next cycle
  assign imem_recv = recv_any & ~owner_q;
  assign dmem_recv = recv_any & owner_q;

  assign rsp      = mmio_q ? mmio_rsp : mem_rsp;
  assign imem_rsp = rsp;
  assign dmem_rsp = rsp;

  // ----------------------------------------
  // Outstanding transaction tracking
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      mmio_q  <= 1'b0;
    end else if (gnt_any) begin
      busy_q  <= 1'b1;          // Open
      owner_q <= sel_d;
      mmio_q  <= win_mmio;
    end else if (recv_any) begin
      busy_q  <= 1'b0;          // Closed by the response
      mmio_q  <= 1'b0;
    end
  end

endmodule

//--- src/frv_core.sv
// ----------------------------------------
// Core system block
// Counters, interrupt controller and memory arbiter
// ----------------------------------------
module frv_core
  import frv_pkg::*;
  import frv_irq_pkg::*;
(
  input  logic        g_clk,             // Global clock
  input  logic        arst_n,            // Async reset, active low
  input  logic        instr_ret,         // Instruction retired
  input  inhibit_t    inhibit,           // Counter stop bits
  output ctr_bundle_t ctr,               // Counter values
  input  logic        mstatus_mie,       // Global interrupt enable
  input  irq_bits_t   mie,               // Per-source enables
  output irq_bits_t   mip,               // Pending bits
  input  logic        int_nmi,           // Non-maskable interrupt
  input  logic        int_external,      // External interrupt line
  input  ext_cause_t  int_extern_cause,  // External cause code
  input  logic        int_software,      // Software interrupt line
  output logic        int_mtime,         // Timer interrupt pending
  output logic        int_trap_req,      // Trap request to write-back
  output cause_t      int_trap_cause,    // Trap cause
  input  logic        int_trap_ack,      // Trap taken
  input  logic        imem_req,          // Fetch port
  input  mem_req_t    imem_pkt,
  output logic        imem_gnt,
  output logic        imem_recv,
  output mem_rsp_t    imem_rsp,
  input  logic        dmem_req,          // Data port
  input  mem_req_t    dmem_pkt,
  output logic        dmem_gnt,
  output logic        dmem_recv,
  output mem_rsp_t    dmem_rsp,
  output logic        mem_req,           // External memory bus
  output mem_req_t    mem_pkt,
  input  logic        mem_gnt,
  input  logic        mem_recv,
  input  mem_rsp_t    mem_rsp
);

  logic     ti_pending;                  // Timer compare hit
  logic     mmio_en;                     // Arbiter to counters
  mem_req_t mmio_req;
  mem_rsp_t mmio_rsp;

  assign int_mtime = mip.mtip;

  frv_counters i_counters (
    .g_clk, .arst_n, .instr_ret, .inhibit, .mmio_en, .mmio_req, .mmio_rsp, .ctr,
    .timer_interrupt (ti_pending)
  );

  frv_interrupt i_interrupts (
    .g_clk, .arst_n, .mstatus_mie, .mie, .mip, .int_trap_req, .int_trap_cause,
    .int_trap_ack,
    .nmi_pending (int_nmi),
    .ex_pending  (int_external),
    .ex_cause    (int_extern_cause),
    .ti_pending  (ti_pending),
    .sw_pending  (int_software)
  );

  frv_mem_arbiter i_arbiter (
    .g_clk, .arst_n,
    .imem_req, .imem_pkt, .imem_gnt, .imem_recv, .imem_rsp,
    .dmem_req, .dmem_pkt, .dmem_gnt, .dmem_recv, .dmem_rsp,
    .mem_req, .mem_pkt, .mem_gnt, .mem_recv, .mem_rsp,
    .mmio_en, .mmio_req, .mmio_rsp
  );

endmodule

//--- dv/frv_core_sva.sv
// ----------------------------------------
// Checker for the core system block
// Counter, MMIO, trap and arbiter rules
// ----------------------------------------
module frv_core_sva
  import frv_pkg::*;
  import frv_irq_pkg::*;
(
  input logic        g_clk, arst_n, instr_ret, mstatus_mie, int_nmi, int_trap_ack,
  input logic        int_external, int_software,
  input inhibit_t    inhibit,
  input ctr_bundle_t ctr,
  input ctr_t        mtimecmp,
  input irq_bits_t   mie, mip,
  input ext_cause_t  int_extern_cause,
  input logic        int_mtime, int_trap_req,
  input cause_t      int_trap_cause,
  input logic        imem_gnt, imem_recv, dmem_req, dmem_gnt, dmem_recv,
  input mem_req_t    imem_pkt, dmem_pkt, mem_pkt, mmio_req,
  input mem_rsp_t    imem_rsp, dmem_rsp,
  input logic        mem_req, mem_gnt, mmio_en
);

  int         err_cnt = 0;                     // Failed assertions
  logic       out_q, own_q, win_q, nmi_d;      // Outstanding txn, owner, MMIO, NMI
  logic       ext_d, sw_d;                     // External and software lines, registered
  word_t      addr_q;                          // Address of outstanding txn
  ext_cause_t xc_d;                            // External cause, pending aligned
  irq_bits_t  pend;                            // Expected pending bits
  irq_bits_t  en;
  cause_t     exp_cause;
  logic       take_exp, d_win, ofs_ok, mmio_wr;
  word_t      d_ofs;

  assign d_win    = (dmem_pkt.addr & MMIO_BASE_MASK) == MMIO_BASE_ADDR;
  assign d_ofs    = dmem_pkt.addr & ~MMIO_BASE_MASK;
  assign ofs_ok   = d_ofs inside {MMIO_OFS_MTIME_LO, MMIO_OFS_MTIME_HI,
                                  MMIO_OFS_MTIMECMP_LO, MMIO_OFS_MTIMECMP_HI};
  assign mmio_wr  = mmio_en & mmio_req.wen;
  assign pend     = '{meip: ext_d, mtip: int_mtime, msip: sw_d};
  assign en       = pend & mie & {3{mstatus_mie}};
  assign take_exp = nmi_d | (|en);

  always_comb begin
    if (nmi_d)         exp_cause = CAUSE_NMI;
    else if (en.meip)  exp_cause = CAUSE_MEI_BASE + cause_t'(xc_d);
    else if (en.msip)  exp_cause = CAUSE_MSI;
    else               exp_cause = CAUSE_MTI;
  end

  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      {out_q, own_q, win_q, nmi_d} <= '0;
      {ext_d, sw_d} <= '0;
      addr_q <= '0;
      xc_d   <= '0;
    end else begin
      nmi_d <= int_nmi;                        // Sources register in one cycle
      ext_d <= int_external;
      sw_d  <= int_software;
      xc_d  <= int_extern_cause;
      if (imem_gnt | dmem_gnt) begin
        out_q  <= 1'b1;
        own_q  <= dmem_gnt;
        addr_q <= dmem_gnt ? dmem_pkt.addr : imem_pkt.addr;
        win_q  <= dmem_gnt & d_win;
      end else if (imem_recv | dmem_recv) begin
        out_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Counters
  a_rst: assert property (@(posedge g_clk) !arst_n |->
    !mem_req && !imem_gnt && !dmem_gnt && !imem_recv && !dmem_recv &&
    !int_trap_req && !int_mtime)
    else begin err_cnt++; $error("ERROR t=%0t outputs active in reset", $time); end
  a_cy: assert property (@(posedge g_clk) disable iff (!arst_n)
    1'b1 |=> ctr.cycle == $past(ctr.cycle) + {63'd0, !$past(inhibit.cy)})
    else begin err_cnt++; $error("ERROR t=%0t ctr.cycle got %0d prev %0d", $time,
      ctr.cycle, $past(ctr.cycle)); end
  a_ir: assert property (@(posedge g_clk) disable iff (!arst_n)
    1'b1 |=> ctr.instret == $past(ctr.instret) + {63'd0, $past(instr_ret && !inhibit.ir)})
    else begin err_cnt++; $error("ERROR t=%0t ctr.instret got %0d prev %0d", $time,
      ctr.instret, $past(ctr.instret)); end
  a_tm: assert property (@(posedge g_clk) disable iff (!arst_n)
    !mmio_wr |=> ctr.mtime == $past(ctr.mtime) + {63'd0, !$past(inhibit.tm)})
    else begin err_cnt++; $error("ERROR t=%0t ctr.mtime got %0d prev %0d", $time,
      ctr.mtime, $past(ctr.mtime)); end
  a_tmr: assert property (@(posedge g_clk) disable iff (!arst_n)
    int_mtime == $past(ctr.mtime >= mtimecmp, 2))
    else begin err_cnt++; $error("ERROR t=%0t int_mtime exp %0b got %0b", $time,
      !int_mtime, int_mtime); end

  // ----------------------------------------
  // MMIO window
  a_nobus: assert property (@(posedge g_clk) disable iff (!arst_n) dmem_req && d_win |-> !mem_req)
    else begin err_cnt++; $error("ERROR t=%0t mem_req exp 0 got 1", $time); end
  a_mrecv: assert property (@(posedge g_clk) disable iff (!arst_n) dmem_gnt && d_win |=> dmem_recv)
    else begin err_cnt++; $error("ERROR t=%0t dmem_recv exp 1 got 0", $time); end
  a_mtime: assert property (@(posedge g_clk) disable iff (!arst_n)
    dmem_gnt && d_win && !dmem_pkt.wen && d_ofs == MMIO_OFS_MTIME_LO |=>
    dmem_rsp.rdata == $past(ctr.mtime[31:0]))
    else begin err_cnt++; $error("ERROR t=%0t dmem_rsp.rdata exp %h got %h", $time,
      $past(ctr.mtime[31:0]), dmem_rsp.rdata); end
  a_merr: assert property (@(posedge g_clk) disable iff (!arst_n)
    dmem_gnt && d_win |=> dmem_rsp.error == $past(!ofs_ok))
    else begin err_cnt++; $error("ERROR t=%0t dmem_rsp.error exp %0b got %0b", $time,
      $past(!ofs_ok), dmem_rsp.error); end

  // ----------------------------------------
  // Trap requests
  a_mip: assert property (@(posedge g_clk) disable iff (!arst_n)
    mip.meip == ext_d && mip.msip == sw_d)
    else begin err_cnt++; $error("ERROR t=%0t mip exp %b got %b", $time, pend, mip); end
  a_raise: assert property (@(posedge g_clk) disable iff (!arst_n)
    !int_trap_req && take_exp |=> int_trap_req && int_trap_cause == $past(exp_cause))
    else begin err_cnt++; $error("ERROR t=%0t int_trap_cause exp %0d got %0d", $time,
      $past(exp_cause), int_trap_cause); end
  a_quiet: assert property (@(posedge g_clk) disable iff (!arst_n)
    !int_trap_req && !take_exp |=> !int_trap_req)
    else begin err_cnt++; $error("ERROR t=%0t int_trap_req exp 0 got 1", $time); end
  a_hold: assert property (@(posedge g_clk) disable iff (!arst_n)
    int_trap_req && !int_trap_ack |=> int_trap_req && $stable(int_trap_cause))
    else begin err_cnt++; $error("ERROR t=%0t int_trap_cause exp %0d got %0d", $time,
      $past(int_trap_cause), int_trap_cause); end
  a_ack: assert property (@(posedge g_clk) disable iff (!arst_n)
    int_trap_req && int_trap_ack |=> !int_trap_req)
    else begin err_cnt++; $error("ERROR t=%0t int_trap_req exp 0 got 1", $time); end

  // ----------------------------------------
  // Arbiter
  a_dfirst: assert property (@(posedge g_clk) disable iff (!arst_n) imem_gnt |-> !dmem_req)
    else begin err_cnt++; $error("ERROR t=%0t imem_gnt exp 0 got 1", $time); end
  a_one: assert property (@(posedge g_clk) disable iff (!arst_n) imem_gnt || dmem_gnt |-> !out_q)
    else begin err_cnt++; $error("ERROR t=%0t second grant while outstanding", $time); end
  a_pkt: assert property (@(posedge g_clk) disable iff (!arst_n)
    mem_req && mem_gnt |-> mem_pkt == (dmem_gnt ? dmem_pkt : imem_pkt))
    else begin err_cnt++; $error("ERROR t=%0t mem_pkt.addr exp %h got %h", $time,
      dmem_gnt ? dmem_pkt.addr : imem_pkt.addr, mem_pkt.addr); end
  a_iown: assert property (@(posedge g_clk) disable iff (!arst_n) imem_recv |-> out_q && !own_q)
    else begin err_cnt++; $error("ERROR t=%0t imem_recv exp 0 got 1", $time); end
  a_down: assert property (@(posedge g_clk) disable iff (!arst_n) dmem_recv |-> out_q && own_q)
    else begin err_cnt++; $error("ERROR t=%0t dmem_recv exp 0 got 1", $time); end
  a_data: assert property (@(posedge g_clk) disable iff (!arst_n)
    (imem_recv || dmem_recv) && !win_q |->
    (own_q ? dmem_rsp.rdata : imem_rsp.rdata) == (addr_q ^ 32'hA5A5_A5A5))
    else begin err_cnt++; $error("ERROR t=%0t rsp.rdata exp %h got %h", $time,
      addr_q ^ 32'hA5A5_A5A5, own_q ? dmem_rsp.rdata : imem_rsp.rdata); end

endmodule

bind frv_core frv_core_sva i_sva (.*, .mtimecmp(i_counters.mtimecmp_q));

//--- dv/tb_frv_core.sv
// ----------------------------------------
// Testbench for the core system block
// Pipeline-side stimulus and a memory model
// ----------------------------------------
module tb_frv_core;
  import frv_pkg::*;
  import frv_irq_pkg::*;

  logic g_clk = 1'b0, arst_n = 1'b0;
  logic instr_ret, mstatus_mie, int_nmi, int_external, int_software, int_trap_ack;
  logic int_mtime, int_trap_req, imem_req, imem_gnt, imem_recv, dmem_req, dmem_gnt, dmem_recv;
  logic mem_req, mem_gnt, mem_recv, rsp_pend;
  inhibit_t inhibit;
  ctr_bundle_t ctr;
  irq_bits_t mie, mip;
  ext_cause_t int_extern_cause;
  cause_t int_trap_cause;
  mem_req_t imem_pkt, dmem_pkt, mem_pkt;
  mem_rsp_t imem_rsp, dmem_rsp, mem_rsp;
  word_t rsp_addr, tm_lo;
  int seed = 32'h180236c9;
  int timeouts = 0;

  frv_core i_dut (.*);

  always #20 g_clk = ~g_clk;               // Period 40

  // ----------------------------------------
  // Memory bus model, random grant delay
  always @(posedge g_clk) begin
    mem_recv <= 1'b0;
    if (mem_gnt && mem_req) begin
      mem_gnt  <= 1'b0;                    // Granted this edge
      rsp_pend <= 1'b1;
      rsp_addr <= mem_pkt.addr;
    end else if (rsp_pend) begin
      mem_recv <= 1'b1;
      mem_rsp  <= '{error: 1'b0, rdata: rsp_addr ^ 32'hA5A5_A5A5};
      rsp_pend <= 1'b0;
    end else begin
      mem_gnt <= mem_req && !mem_gnt && ($random(seed) % 2 != 0);
    end
  end

  // One access on the fetch or data port, waits for grant and recv
  task automatic access(input bit is_d, input word_t addr, input bit wen, input word_t wd);
    int n;
    @(posedge g_clk);
    if (is_d) begin
      dmem_req <= 1'b1;
      dmem_pkt <= '{wen: wen, strb: 4'hF, addr: addr, wdata: wd};
    end else begin
      imem_req <= 1'b1;
      imem_pkt <= '{wen: 1'b0, strb: 4'h0, addr: addr, wdata: '0};
    end
    n = 0;
    do begin
      @(negedge g_clk);
      n++;
    end while (!(is_d ? dmem_gnt : imem_gnt) && n < 50);
    if (!(is_d ? dmem_gnt : imem_gnt)) begin
      timeouts++;
      $display("Timeout: no grant for address %h", addr);
    end
    @(posedge g_clk);
    if (is_d) dmem_req <= 1'b0;
    else      imem_req <= 1'b0;
    n = 0;
    do begin
      @(negedge g_clk);
      n++;
    end while (!(is_d ? dmem_recv : imem_recv) && n < 50);
    if (!(is_d ? dmem_recv : imem_recv)) begin
      timeouts++;
      $display("Timeout: no response for address %h", addr);
    end
  endtask

  // Waits for a trap request and acknowledges it, new enables go with the ack
  task automatic take_trap(input int hold, input irq_bits_t next_mie);
    int n;
    n = 0;
    do begin
      @(negedge g_clk);
      n++;
    end while (!int_trap_req && n < 40);
    if (!int_trap_req) begin
      timeouts++;
      $display("Timeout: no trap request raised");
    end
    repeat (hold) @(posedge g_clk);          // Request must stay stable
    @(posedge g_clk) begin
      int_trap_ack <= 1'b1;
      mie          <= next_mie;              // Seen in the idle cycle after the ack
    end
    @(posedge g_clk) int_trap_ack <= 1'b0;
  endtask

  initial begin
    {instr_ret, mstatus_mie, int_nmi, int_external, int_software, int_trap_ack} = '0;
    {imem_req, dmem_req, mem_gnt, mem_recv, rsp_pend} = '0;
    inhibit = '0;
    mie = '0;
    int_extern_cause = 4'd5;
    imem_pkt = '0;
    dmem_pkt = '0;
    mem_rsp = '0;
    rsp_addr = '0;
    repeat (4) @(posedge g_clk);
    arst_n <= 1'b1;
    // ----------------------------------------
    // Counters and inhibit
    repeat (4) @(posedge g_clk) instr_ret <= ~instr_ret;
    @(posedge g_clk) inhibit <= '{cy: 1'b1, tm: 1'b1, ir: 1'b1};
    repeat (4) @(posedge g_clk) instr_ret <= ~instr_ret;
    @(posedge g_clk) begin
      inhibit <= '0;
      instr_ret <= 1'b0;
    end
    // ----------------------------------------
    // MMIO reads and the timer
    access(1, MMIO_BASE_ADDR | MMIO_OFS_MTIME_HI, 0, '0);
    access(1, MMIO_BASE_ADDR | MMIO_OFS_MTIMECMP_LO, 0, '0);
    access(1, MMIO_BASE_ADDR | 32'h10, 0, '0);  // Undefined offset
    access(1, MMIO_BASE_ADDR | MMIO_OFS_MTIME_LO, 0, '0);
    tm_lo = dmem_rsp.rdata;
    access(1, MMIO_BASE_ADDR | MMIO_OFS_MTIMECMP_LO, 1, tm_lo + 32'd30);
    access(1, MMIO_BASE_ADDR | MMIO_OFS_MTIMECMP_HI, 1, '0);
    @(posedge g_clk) begin
      mie <= '{meip: 1'b0, mtip: 1'b1, msip: 1'b0};
      mstatus_mie <= 1'b1;
    end
    take_trap(2, '{meip: 1'b1, mtip: 1'b0, msip: 1'b1});
    // ----------------------------------------
    // Priority and masking
    @(posedge g_clk) begin
      int_external <= 1'b1;
      int_software <= 1'b1;
    end
    take_trap(3, '{meip: 1'b0, mtip: 1'b0, msip: 1'b1});  // Software comes next
    @(posedge g_clk) int_external <= 1'b0;
    take_trap(1, '0);
    @(posedge g_clk) begin
      mstatus_mie <= 1'b0;
      mie <= '1;                               // All pending, globally masked
    end
    repeat (8) @(posedge g_clk);
    @(posedge g_clk) int_nmi <= 1'b1;
    @(posedge g_clk) int_nmi <= 1'b0;
    take_trap(1, '0);
    @(posedge g_clk) int_software <= 1'b0;
    // ----------------------------------------
    // Arbitration and memory data
    fork
      access(0, 32'h0000_0100, 0, '0);
      access(1, 32'h0000_2000, 0, '0);
    join
    fork
      access(0, 32'h0000_0104, 0, '0);
      access(1, MMIO_BASE_ADDR | MMIO_OFS_MTIME_LO, 0, '0);
    join
    repeat (6) begin
      access($random(seed) % 2 != 0, ($random(seed) & 32'hFFFF_0FFC) | 32'h0001_0000, 0, '0);
    end
    repeat (4) @(posedge g_clk);
    $display("Done: %0d assertion errors, %0d timeouts", i_dut.i_sva.err_cnt, timeouts);
    if (i_dut.i_sva.err_cnt == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Overall run limit
  initial begin
    repeat (5000) @(posedge g_clk);
    $display("Timeout: run did not finish");
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- build.f
src/frv_pkg.sv
src/frv_irq_pkg.sv
src/frv_counters.sv
src/frv_interrupt.sv
src/frv_mem_arbiter.sv
src/frv_core.sv
dv/frv_core_sva.sv
dv/tb_frv_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_frv_core
FILELIST  ?= build.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
